// File: hdl/trx_defines.svh
`ifndef TRX_DEFINES_SVH
`define TRX_DEFINES_SVH

//**************************************************************************
// Datapath widths
//**************************************************************************
`define TRX_SAMPLE_W    16  // Converter sample width
`define TRX_GRP_CHANS   4   // Channels per group

//**************************************************************************
// Converter configuration port
//**************************************************************************
`define TRX_CFG_ADDR_W  7   // Register address
`define TRX_CFG_DATA_W  8   // Register data
`define TRX_CFG_WORD_W  16  // Write bit, address, data
`define TRX_SCLK_HALF   10  // Half sclk period in clk_200m cycles

//**************************************************************************
// Level monitor
//**************************************************************************
`define TRX_MON_WINDOW  16  // Valid frames per window
`define TRX_MON_SUM_W   22  // Holds 64 magnitudes of up to 32768

`endif

// File: hdl/trx_pkg.sv
`include "trx_defines.svh"

package trx_pkg;

   // One converter sample
   typedef logic [`TRX_SAMPLE_W-1:0] sample_t;

   // ADC side, offset binary
   typedef struct packed {
      logic                             valid;  // Frame strobe
      sample_t [`TRX_GRP_CHANS-1:0]     smp;    // Channel 0 in low slot
   } adc_frame_t;

   // DAC side, two's complement with parity
   typedef struct packed {
      logic                             valid;  // Frame strobe
      sample_t [`TRX_GRP_CHANS-1:0]     smp;    // Signed samples
      logic [`TRX_GRP_CHANS-1:0]        par;    // Even parity per sample
   } dac_frame_t;

   // Serial config targets
   typedef enum logic [1:0] {
      DEV_ADC0 = 2'd0,
      DEV_ADC1 = 2'd1,
      DEV_DAC0 = 2'd2,
      DEV_DAC1 = 2'd3
   } dev_sel_t;

   typedef struct packed {
      dev_sel_t                         dev;    // Target converter
      logic [`TRX_CFG_ADDR_W-1:0]       addr;   // Register address
      logic [`TRX_CFG_DATA_W-1:0]       data;   // Register data
   } cfg_cmd_t;

   // One 3-wire converter bus
   typedef struct packed {
      logic csb;   // Chip select, active low
      logic sclk;  // Serial clock
      logic sdio;  // Serial data
   } spi_bus_t;

   typedef struct packed {
      logic                             sum_flag;  // Window sum at or over limit
      logic                             pk_flag;   // Any channel over peak
      logic [`TRX_GRP_CHANS-1:0]        over;      // Per-channel over peak
   } level_flags_t;

endpackage

// File: hdl/cfg_spi_master.sv
`timescale 1ns/1ps
`include "trx_defines.svh"

module cfg_spi_master (
   input  logic                    clk_200m,
   input  logic                    arst_n,
   input  logic                    cfg_req,   // Host request, four-phase
   input  trx_pkg::cfg_cmd_t       cfg_cmd,   // Held stable while req is high
   output logic                    cfg_ack,   // Word done
   output trx_pkg::spi_bus_t [3:0] cfg_spi    // Indexed by dev_sel_t
);

   localparam int unsigned N_DEV  = 4;
   localparam int unsigned HALF_W = $clog2(`TRX_SCLK_HALF);
   localparam int unsigned BIT_W  = $clog2(`TRX_CFG_WORD_W);
   localparam int unsigned WORD_W = `TRX_CFG_WORD_W;

   localparam trx_pkg::spi_bus_t IDLE_BUS = '{csb: 1'b1, sclk: 1'b0, sdio: 1'b0};

   typedef enum logic [1:0] {
      ST_IDLE,    // Wait for req
      ST_SHIFT,   // Clock out the word
      ST_FINISH,  // Hold csb low for a half period
      ST_ACKW     // Handshake with host
   } state_t;

   state_t              state_q;
   logic [HALF_W-1:0]   half_cnt_q;  // Half-period timer
   logic [BIT_W-1:0]    bit_cnt_q;   // Falling edges seen
   logic [WORD_W-1:0]   shift_q;     // MSB goes out first
   trx_pkg::dev_sel_t   dev_q;       // Latched target
   logic                csb_q;
   logic                sclk_q;
   logic                half_done;
   logic                accept;
   logic                sclk_fall;
   trx_pkg::spi_bus_t   live_bus;

   assign half_done = (half_cnt_q == HALF_W'(`TRX_SCLK_HALF - 1));
   assign accept    = (state_q == ST_IDLE) && cfg_req;
   assign sclk_fall = (state_q == ST_SHIFT) && half_done && sclk_q;

   //***********************************************************************
   // Control FSM
   //***********************************************************************
   always_ff @(posedge clk_200m or negedge arst_n) begin
      if (!arst_n) begin
         state_q    <= ST_IDLE;
         half_cnt_q <= '0;
         bit_cnt_q  <= '0;
         dev_q      <= trx_pkg::DEV_ADC0;
         csb_q      <= 1'b1;
         sclk_q     <= 1'b0;
         cfg_ack    <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               half_cnt_q <= '0;
               bit_cnt_q  <= '0;
               if (cfg_req) begin
                  dev_q   <= cfg_cmd.dev;       // Select bus for this word
                  csb_q   <= 1'b0;              // First bit goes out with csb
                  state_q <= ST_SHIFT;
               end
            end
            ST_SHIFT: begin
               if (half_done) begin
                  half_cnt_q <= '0;
                  sclk_q     <= ~sclk_q;        // Rise samples, fall advances
                  if (sclk_q) begin
                     bit_cnt_q <= bit_cnt_q + 1'b1;
                     if (bit_cnt_q == BIT_W'(WORD_W - 1)) begin
                        state_q <= ST_FINISH;   // Sixteenth falling edge
                     end
                  end
               end else begin
                  half_cnt_q <= half_cnt_q + 1'b1;
               end
            end
            ST_FINISH: begin
               if (half_done) begin
                  half_cnt_q <= '0;
                  csb_q      <= 1'b1;           // Release after half period
                  state_q    <= ST_ACKW;
               end else begin
                  half_cnt_q <= half_cnt_q + 1'b1;
               end
            end
            ST_ACKW: begin
               if (!cfg_ack) begin
                  cfg_ack <= 1'b1;              // One cycle after csb high
               end else if (!cfg_req) begin
                  cfg_ack <= 1'b0;              // Host let go
                  state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Word register, loaded on accept
   always_ff @(posedge clk_200m) begin
      if (accept) begin
         shift_q <= {1'b0, cfg_cmd.addr, cfg_cmd.data};  // Write bit is 0
      end else if (sclk_fall) begin
         shift_q <= {shift_q[WORD_W-2:0], 1'b0};         // Next bit while low
      end
   end

   //***********************************************************************
   // Bus steering
   //***********************************************************************
   assign live_bus = '{csb:  csb_q,
                       sclk: sclk_q,
                       sdio: (state_q == ST_SHIFT) & shift_q[WORD_W-1]};

   for (genvar d = 0; d < N_DEV; d++) begin : g_bus
      assign cfg_spi[d] = (dev_q == 2'(d)) ? live_bus : IDLE_BUS;  // Others idle
   end

endmodule

// File: hdl/sample_format.sv
`timescale 1ns/1ps
`include "trx_defines.svh"

module sample_format (
   input  logic                 clk_200m,
   input  logic                 arst_n,
   input  trx_pkg::adc_frame_t  adc_in,   // Offset binary from ADC
   output trx_pkg::dac_frame_t  dac_out   // Two's complement plus parity
);

   localparam int unsigned N_CH = `TRX_GRP_CHANS;

   // Flipping the MSB maps offset binary onto two's complement
   localparam trx_pkg::sample_t MSB_FLIP = {1'b1, {(`TRX_SAMPLE_W-1){1'b0}}};

   logic                          v1_q;     // Stage 1 valid
   logic                          v2_q;     // Stage 2 valid
   trx_pkg::sample_t [N_CH-1:0]   smp1_q;   // Converted samples
   trx_pkg::sample_t [N_CH-1:0]   smp2_q;   // Output samples
   logic [N_CH-1:0]               par2_q;   // Output parity

   //***********************************************************************
   // Valid pipe
   //***********************************************************************
   always_ff @(posedge clk_200m or negedge arst_n) begin
      if (!arst_n) begin
         v1_q <= 1'b0;
         v2_q <= 1'b0;
      end else begin
         v1_q <= adc_in.valid;
         v2_q <= v1_q;      // Two frames may be in flight
      end
   end

   //***********************************************************************
   // Data pipe
   //***********************************************************************
   always_ff @(posedge clk_200m) begin
      for (int i = 0; i < N_CH; i++) begin
         if (adc_in.valid) begin
            smp1_q[i] <= adc_in.smp[i] ^ MSB_FLIP;   // Sign convert
         end
         if (v1_q) begin
            smp2_q[i] <= smp1_q[i];
            par2_q[i] <= ^smp1_q[i];                 // Even parity bit
         end
      end
   end

   assign dac_out = '{valid: v2_q,
                      smp:   smp2_q,
                      par:   par2_q};

endmodule

// File: hdl/level_monitor.sv
`timescale 1ns/1ps
`include "trx_defines.svh"

module level_monitor (
   input  logic                        clk_200m,
   input  logic                        arst_n,
   input  trx_pkg::dac_frame_t         frame,       // Signed group frame
   input  logic [`TRX_MON_SUM_W-1:0]   sum_thresh,  // Window sum limit
   input  trx_pkg::sample_t            pk_thresh,   // Magnitude limit
   output trx_pkg::level_flags_t       flags        // Last window result
);

   localparam int unsigned N_CH  = `TRX_GRP_CHANS;
   localparam int unsigned SUM_W = `TRX_MON_SUM_W;
   localparam int unsigned MSB   = `TRX_SAMPLE_W - 1;
   localparam int unsigned CNT_W = $clog2(`TRX_MON_WINDOW);

   trx_pkg::sample_t [N_CH-1:0]  mag;        // Unsigned magnitudes
   logic [N_CH-1:0]              over_now;   // Over peak this frame
   logic [N_CH-1:0]              over_nxt;
   logic [N_CH-1:0]              over_q;     // Sticky over bits
   logic [SUM_W-1:0]             frame_sum;  // Sum of this frame
   logic [SUM_W-1:0]             sum_nxt;
   logic [SUM_W-1:0]             sum_q;      // Running window sum
   logic [CNT_W-1:0]             cnt_q;      // Frames in window
   logic                         win_end;
   trx_pkg::level_flags_t        flags_q;

   //***********************************************************************
   // Per-frame magnitude and peak test
   //***********************************************************************
   always_comb begin
      frame_sum = '0;
      for (int i = 0; i < N_CH; i++) begin
         // 0x8000 reads back as 32768 unsigned
         mag[i]      = frame.smp[i][MSB] ? (~frame.smp[i] + 1'b1) : frame.smp[i];
         over_now[i] = (mag[i] > pk_thresh);    // Strictly above
         frame_sum   = frame_sum + SUM_W'(mag[i]);
      end
   end

   assign sum_nxt  = sum_q + frame_sum;
   assign over_nxt = over_q | over_now;
   assign win_end  = frame.valid && (cnt_q == CNT_W'(`TRX_MON_WINDOW - 1));

   //***********************************************************************
   // Window accumulate and flag load
   //***********************************************************************
   always_ff @(posedge clk_200m or negedge arst_n) begin
      if (!arst_n) begin
         cnt_q   <= '0;
         sum_q   <= '0;
         over_q  <= '0;
         flags_q <= '0;
      end else if (frame.valid) begin
         if (win_end) begin
            flags_q.sum_flag <= (sum_nxt >= sum_thresh);
            flags_q.pk_flag  <= |over_nxt;         // Any channel tripped
            flags_q.over     <= over_nxt;
            cnt_q            <= '0;                // Start next window
            sum_q            <= '0;
            over_q           <= '0;
         end else begin
            cnt_q  <= cnt_q + 1'b1;
            sum_q  <= sum_nxt;
            over_q <= over_nxt;
         end
      end
   end

   assign flags = flags_q;   // Held until next window

endmodule

// File: hdl/trx_8t8r_top.sv
`timescale 1ns/1ps
`include "trx_defines.svh"

module trx_8t8r_top (
   input  logic                        clk_200m,
   input  logic                        arst_n,
   // ADC frames in
   input  trx_pkg::adc_frame_t         adc_grp_n,
   input  trx_pkg::adc_frame_t         adc_grp_w,
   // DAC frames out
   output trx_pkg::dac_frame_t         dac_grp_n,
   output trx_pkg::dac_frame_t         dac_grp_w,
   // Level monitor
   input  logic [`TRX_MON_SUM_W-1:0]   sum_thresh,
   input  trx_pkg::sample_t            pk_thresh,
   output trx_pkg::level_flags_t       flags_n,    // N4 sum and peak
   output trx_pkg::level_flags_t       flags_w,    // W4 sum and peak
   output logic [7:0]                  io_db_cb,   // Board comm lines
   // Converter configuration
   input  logic                        cfg_req,
   input  trx_pkg::cfg_cmd_t           cfg_cmd,
   output logic                        cfg_ack,
   output trx_pkg::spi_bus_t [3:0]     cfg_spi     // adc0, adc1, dac0, dac1
);

   //***********************************************************************
   // Group n datapath
   //***********************************************************************
   sample_format u_fmt_n (
      .clk_200m   ( clk_200m   ),
      .arst_n     ( arst_n     ),
      .adc_in     ( adc_grp_n  ),
      .dac_out    ( dac_grp_n  )
   );

   level_monitor u_mon_n (
      .clk_200m   ( clk_200m   ),
      .arst_n     ( arst_n     ),
      .frame      ( dac_grp_n  ),   // Monitor the outgoing frames
      .sum_thresh ( sum_thresh ),
      .pk_thresh  ( pk_thresh  ),
      .flags      ( flags_n    )
   );

   //***********************************************************************
   // Group w datapath
   //***********************************************************************
   sample_format u_fmt_w (
      .clk_200m   ( clk_200m   ),
      .arst_n     ( arst_n     ),
      .adc_in     ( adc_grp_w  ),
      .dac_out    ( dac_grp_w  )
   );

   level_monitor u_mon_w (
      .clk_200m   ( clk_200m   ),
      .arst_n     ( arst_n     ),
      .frame      ( dac_grp_w  ),
      .sum_thresh ( sum_thresh ),   // Shared limits
      .pk_thresh  ( pk_thresh  ),
      .flags      ( flags_w    )
   );

   // Lines 0-3 from group n, 4-7 from group w
   assign io_db_cb = {flags_w.over, flags_n.over};

   //***********************************************************************
   // Configuration master
   //***********************************************************************
   cfg_spi_master u_cfg (
      .clk_200m   ( clk_200m   ),
      .arst_n     ( arst_n     ),
      .cfg_req    ( cfg_req    ),
      .cfg_cmd    ( cfg_cmd    ),
      .cfg_ack    ( cfg_ack    ),
      .cfg_spi    ( cfg_spi    )
   );

endmodule

// File: verif/tb_trx_8t8r.sv
`timescale 1ns/1ps
`include "trx_defines.svh"

module tb_trx_8t8r;

   localparam int N_CH        = `TRX_GRP_CHANS;
   localparam int WIN         = `TRX_MON_WINDOW;
   localparam int WORD_W      = `TRX_CFG_WORD_W;
   localparam int RAND_FRAMES = 4 * WIN;                          // Valid frames per group
   localparam int WIN_FRAMES  = 3 * WIN;                          // Shaped level windows
   localparam int N_FRAMES    = 4 * (RAND_FRAMES + WIN_FRAMES);   // Budget with gaps and idle
   localparam int N_CMDS      = 6;
   localparam int RUN_LIMIT   = N_FRAMES * 20 + N_CMDS * 4000;    // In ns
   localparam int ACK_LIMIT   = 1000;                             // Cycles per handshake phase
   localparam logic [31:0] SEED = 32'h5e02_be1d;

   typedef trx_pkg::sample_t [WIN*N_CH-1:0] win_buf_t;   // One window, frame major

   logic                         clk_200m;
   logic                         arst_n;
   trx_pkg::adc_frame_t          adc_grp_n;
   trx_pkg::adc_frame_t          adc_grp_w;
   trx_pkg::dac_frame_t          dac_grp_n;
   trx_pkg::dac_frame_t          dac_grp_w;
   logic [`TRX_MON_SUM_W-1:0]    sum_thresh;
   trx_pkg::sample_t             pk_thresh;
   trx_pkg::level_flags_t        flags_n;
   trx_pkg::level_flags_t        flags_w;
   logic [7:0]                   io_db_cb;
   logic                         cfg_req;
   trx_pkg::cfg_cmd_t            cfg_cmd;
   logic                         cfg_ack;
   trx_pkg::spi_bus_t [3:0]      cfg_spi;

   int                     err_cnt;
   int                     chk_cnt;
   bit                     cmp_on;                 // DAC compare running
   trx_pkg::dac_frame_t    exp_n_q[$];             // Expected frames, group n
   trx_pkg::dac_frame_t    exp_w_q[$];
   win_buf_t               win_n;                  // Window reference buffers
   win_buf_t               win_w;
   int                     win_cnt_n;
   int                     win_cnt_w;
   trx_pkg::level_flags_t  exp_flags_n;            // Last completed window
   trx_pkg::level_flags_t  exp_flags_w;
   logic [WORD_W-1:0]      shift_w [4];            // Words rebuilt from sdio
   int                     bits_seen [4];
   logic [WORD_W-1:0]      last_word [4];
   int                     last_bits [4];
   int                     words_done [4];
   bit                     bus_active [4];         // Any bus movement seen
   trx_pkg::spi_bus_t [3:0] prev_spi;
   logic                   prev_ack;
   int                     cyc;
   int                     csb_rise_cyc;

   trx_8t8r_top dut (
      .clk_200m   ( clk_200m   ),
      .arst_n     ( arst_n     ),
      .adc_grp_n  ( adc_grp_n  ),
      .adc_grp_w  ( adc_grp_w  ),
      .dac_grp_n  ( dac_grp_n  ),
      .dac_grp_w  ( dac_grp_w  ),
      .sum_thresh ( sum_thresh ),
      .pk_thresh  ( pk_thresh  ),
      .flags_n    ( flags_n    ),
      .flags_w    ( flags_w    ),
      .io_db_cb   ( io_db_cb   ),
      .cfg_req    ( cfg_req    ),
      .cfg_cmd    ( cfg_cmd    ),
      .cfg_ack    ( cfg_ack    ),
      .cfg_spi    ( cfg_spi    )
   );

   initial begin
      clk_200m = 1'b0;
      forever #5 clk_200m = ~clk_200m;   // 100 MHz sim clock
   end

   //**************************************************************************
   // Checking helpers and reference models
   //**************************************************************************
   task automatic check(input string name, input logic [71:0] exp_v, input logic [71:0] act_v);
      chk_cnt++;
      if (exp_v !== act_v) begin
         err_cnt++;
         $display("** Error %s: expected %0h, actual %0h at %0t", name, exp_v, act_v, $time);
      end
   endtask

   task automatic report_failure(input string what);
      err_cnt++;
      $display("Failure at %0t: %s", $time, what);
   endtask

   // Offset binary code minus midscale gives the signed sample
   function automatic trx_pkg::dac_frame_t expect_dac(input trx_pkg::adc_frame_t adc);
      trx_pkg::dac_frame_t d;
      int v;
      int ones;
      d = '0;
      d.valid = adc.valid;
      for (int i = 0; i < N_CH; i++) begin
         v = int'(adc.smp[i]) - 32768;
         d.smp[i] = trx_pkg::sample_t'(v);
         ones = 0;
         for (int b = 0; b < `TRX_SAMPLE_W; b++) begin
            ones += int'(d.smp[i][b]);
         end
         d.par[i] = ones[0];   // Makes total ones even
      end
      return d;
   endfunction

   function automatic trx_pkg::level_flags_t expect_flags(input win_buf_t win,
         input logic [`TRX_MON_SUM_W-1:0] s_thr, input trx_pkg::sample_t p_thr);
      trx_pkg::level_flags_t f;
      longint sum;
      int mag;
      f = '0;
      sum = 0;
      for (int k = 0; k < WIN*N_CH; k++) begin
         mag = int'($signed(win[k]));
         if (mag < 0) begin
            mag = -mag;                              // -32768 gives 32768
         end
         sum += mag;
         if (mag > int'(p_thr)) begin
            f.over[k % N_CH] = 1'b1;                 // Strictly above limit
         end
      end
      f.sum_flag = (sum >= longint'(s_thr));
      f.pk_flag  = |f.over;
      return f;
   endfunction

   task automatic record_window(input trx_pkg::dac_frame_t d, inout win_buf_t win,
         inout int cnt, inout trx_pkg::level_flags_t ef);
      if (d.valid) begin
         for (int i = 0; i < N_CH; i++) begin
            win[cnt*N_CH + i] = d.smp[i];
         end
         cnt++;
         if (cnt == WIN) begin
            ef  = expect_flags(win, sum_thresh, pk_thresh);   // Window closes
            cnt = 0;
         end
      end
   endtask

   task automatic compare_dac(input string name, input trx_pkg::dac_frame_t exp_f,
         input trx_pkg::dac_frame_t act_f);
      check({name, " valid"}, exp_f.valid, act_f.valid);
      if (exp_f.valid && act_f.valid) begin
         check({name, " samples"}, exp_f.smp, act_f.smp);
         check({name, " parity"}, exp_f.par, act_f.par);
      end
   endtask

   //**************************************************************************
   // Comparison and bus monitor processes
   //**************************************************************************
   always @(negedge clk_200m) begin
      if (cmp_on) begin
         exp_n_q.push_back(expect_dac(adc_grp_n));
         exp_w_q.push_back(expect_dac(adc_grp_w));
         if (exp_n_q.size() > 2) begin
            compare_dac("dac_grp_n", exp_n_q.pop_front(), dac_grp_n);   // Two cycles back
         end
         if (exp_w_q.size() > 2) begin
            compare_dac("dac_grp_w", exp_w_q.pop_front(), dac_grp_w);
         end
      end
   end

   always @(negedge clk_200m) begin
      if (arst_n) begin
         cyc++;
         for (int d = 0; d < 4; d++) begin
            if (!cfg_spi[d].csb || cfg_spi[d].sclk || cfg_spi[d].sdio) begin
               bus_active[d] = 1'b1;
            end
            if (!cfg_spi[d].csb && cfg_spi[d].sclk && !prev_spi[d].sclk) begin
               shift_w[d] = {shift_w[d][WORD_W-2:0], cfg_spi[d].sdio};   // Rising sclk
               bits_seen[d]++;
            end
            if (cfg_spi[d].csb && !prev_spi[d].csb) begin
               last_word[d] = shift_w[d];    // Word closed by csb
               last_bits[d] = bits_seen[d];
               words_done[d]++;
               shift_w[d]   = '0;
               bits_seen[d] = 0;
               csb_rise_cyc = cyc;
            end
            if (cfg_ack && !cfg_spi[d].csb) begin
               report_failure($sformatf("csb of bus %0d low while cfg_ack is high", d));
            end
         end
         if (cfg_ack && !prev_ack) begin
            check("cfg_ack delay after csb rise", 1, cyc - csb_rise_cyc);
         end
         prev_spi = cfg_spi;
         prev_ack = cfg_ack;
      end
   end

   //**************************************************************************
   // Stimulus tasks
   //**************************************************************************
   task automatic drive_cycle(input trx_pkg::adc_frame_t fn, input trx_pkg::adc_frame_t fw);
      @(posedge clk_200m);
      #1;
      adc_grp_n = fn;
      adc_grp_w = fw;
      record_window(expect_dac(fn), win_n, win_cnt_n, exp_flags_n);
      record_window(expect_dac(fw), win_w, win_cnt_w, exp_flags_w);
   endtask

   function automatic trx_pkg::adc_frame_t random_frame(input bit allow);
      trx_pkg::adc_frame_t a;
      a.valid = allow && ($urandom % 4 != 0);   // About one gap in four
      for (int i = 0; i < N_CH; i++) begin
         case ($urandom % 8)
            0:       a.smp[i] = 16'h0000;      // Negative full scale
            1:       a.smp[i] = 16'h8000;      // Midscale
            2:       a.smp[i] = 16'hffff;      // Positive full scale
            default: a.smp[i] = trx_pkg::sample_t'($urandom);
         endcase
      end
      return a;
   endfunction

   // Offset binary code with magnitude up to amp
   function automatic trx_pkg::sample_t bounded_code(input int amp);
      int v;
      v = int'($urandom % (2*amp + 1)) - amp;
      return trx_pkg::sample_t'(v + 32768);
   endfunction

   function automatic trx_pkg::adc_frame_t window_frame(input int w, input bit grp_w,
         input int f);
      trx_pkg::adc_frame_t a;
      bit big;
      a = '0;
      a.valid = 1'b1;
      for (int i = 0; i < N_CH; i++) begin
         big = (w == 2) || (w == 1 && ((i < 2) != grp_w));   // Loud channels
         a.smp[i] = bounded_code(big ? 32767 : 1000);
      end
      if (w == 1 && f == 0) begin
         a.smp[grp_w ? 3 : 0] = 16'h0000;   // Forces one over bit
      end
      return a;
   endfunction

   task automatic check_flags(input string name);
      repeat (4) drive_cycle('0, '0);       // Drain the pipeline
      @(negedge clk_200m);
      check({name, " flags_n"}, exp_flags_n, flags_n);
      check({name, " flags_w"}, exp_flags_w, flags_w);
      check({name, " io_db_cb"}, {exp_flags_w.over, exp_flags_n.over}, io_db_cb);
   endtask

   task automatic check_reset_state();
      @(negedge clk_200m);
      for (int d = 0; d < 4; d++) begin
         check($sformatf("reset bus%0d", d), 3'b100, cfg_spi[d]);   // csb high only
      end
      check("reset cfg_ack", 0, cfg_ack);
      check("reset dac_grp_n valid", 0, dac_grp_n.valid);
      check("reset dac_grp_w valid", 0, dac_grp_w.valid);
      check("reset flags_n", 0, flags_n);
      check("reset flags_w", 0, flags_w);
      check("reset io_db_cb", 0, io_db_cb);
   endtask

   task automatic random_frames();
      trx_pkg::adc_frame_t fn;
      trx_pkg::adc_frame_t fw;
      int sent_n;
      int sent_w;
      sent_n = 0;
      sent_w = 0;
      while (sent_n < RAND_FRAMES || sent_w < RAND_FRAMES) begin
         fn = random_frame(sent_n < RAND_FRAMES);   // Stop at whole windows
         fw = random_frame(sent_w < RAND_FRAMES);
         if (fn.valid) sent_n++;
         if (fw.valid) sent_w++;
         drive_cycle(fn, fw);
      end
   endtask

   task automatic level_windows();
      @(posedge clk_200m);
      #1;
      sum_thresh = 22'd200000;    // Quiet window stays below
      pk_thresh  = 16'd30000;
      for (int w = 0; w < WIN_FRAMES / WIN; w++) begin
         for (int f = 0; f < WIN; f++) begin
            if ($urandom % 4 == 0) drive_cycle('0, '0);
            drive_cycle(window_frame(w, 1'b0, f), window_frame(w, 1'b1, f));
         end
         check_flags($sformatf("level window %0d", w));
      end
   endtask

   task automatic run_cmd(input trx_pkg::cfg_cmd_t cmd);
      string name;
      int d;
      int done_before;
      int waited;
      d = int'(cmd.dev);
      name = $sformatf("cfg dev%0d", d);
      done_before = words_done[d];
      for (int k = 0; k < 4; k++) begin
         bus_active[k] = 1'b0;
      end
      cfg_cmd = cmd;           // Entered right after posedge
      cfg_req = 1'b1;
      waited  = 0;
      while (!cfg_ack && waited < ACK_LIMIT) begin
         @(posedge clk_200m);
         #1;
         waited++;
      end
      if (!cfg_ack) report_failure({name, ": cfg_ack never rose"});
      check({name, " words"}, 1, words_done[d] - done_before);
      check({name, " bits"}, WORD_W, last_bits[d]);
      check({name, " word"}, {1'b0, cmd.addr, cmd.data}, last_word[d]);
      for (int k = 0; k < 4; k++) begin
         if (k != d) check($sformatf("%s bus%0d idle", name, k), 0, bus_active[k]);
      end
      @(posedge clk_200m);
      #1;
      cfg_req = 1'b0;
      waited  = 0;
      while (cfg_ack && waited < ACK_LIMIT) begin
         @(posedge clk_200m);
         #1;
         waited++;
      end
      check({name, " ack fall latency"}, 1, waited);
   endtask

   task automatic config_commands();
      trx_pkg::cfg_cmd_t cmd;
      @(posedge clk_200m);
      #1;
      for (int d = 0; d < 4; d++) begin
         cmd.dev  = trx_pkg::dev_sel_t'(d);
         cmd.addr = 7'($urandom);
         cmd.data = 8'($urandom);
         run_cmd(cmd);          // Each one back to back
      end
      cmd = '{dev: trx_pkg::DEV_DAC1, addr: 7'h7f, data: 8'h00};
      run_cmd(cmd);
      cmd = '{dev: trx_pkg::DEV_ADC0, addr: 7'h00, data: 8'hff};
      run_cmd(cmd);
   endtask

   task automatic finish_run();
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   endtask

   //**************************************************************************
   // Main sequence and watchdog
   //**************************************************************************
   initial begin
      int seed_ret;
      seed_ret   = $urandom(SEED);
      arst_n     = 1'b0;
      adc_grp_n  = '0;
      adc_grp_w  = '0;
      sum_thresh = 22'd1000000;   // Near mean of random windows
      pk_thresh  = 16'd30000;
      cfg_req    = 1'b0;
      cfg_cmd    = '0;
      prev_spi   = {4{3'b100}};
      prev_ack   = 1'b0;
      for (int d = 0; d < 4; d++) begin
         shift_w[d]   = '0;
         last_word[d] = '0;
      end
      repeat (8) @(posedge clk_200m);
      #1;
      arst_n = 1'b1;
      check_reset_state();
      cmp_on = 1'b1;
      random_frames();
      check_flags("random windows");
      level_windows();
      config_commands();
      repeat (5) @(posedge clk_200m);
      finish_run();
   end

   initial begin
      #(RUN_LIMIT);
      report_failure("watchdog expired before the tests finished");
      finish_run();
   end

endmodule

// File: compile.f
+incdir+hdl
hdl/trx_pkg.sv
hdl/cfg_spi_master.sv
hdl/sample_format.sv
hdl/level_monitor.sv
hdl/trx_8t8r_top.sv
verif/tb_trx_8t8r.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the trx_8t8r testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_trx_8t8r

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f compile.f -o "V$TOP"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

grep -qx "all tests passed" "$LOG"
if [ $? -ne 0 ]; then
   echo "Simulation reported failure, see $LOG"
   exit 1
fi

echo "Simulation passed"
exit 0
